// ==== compile.f ====
+incdir+include
verilog/mon_pkg.sv
verilog/mon_cmd_decoder.sv
verilog/mon_mem_access.sv
verilog/mon_resp_sender.sv
verilog/mon_iram.sv
verilog/mon_dram.sv
verilog/mon_top.sv
dv/tb_mon_top.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module tb_mon_top -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/tb_mon_top.sv ====
`timescale 1ns/1ns
`include "mon_consts.svh"

module tb_mon_top;
	import mon_pkg::*;

	localparam int WAIT_LIMIT = 4000;

	logic clk;
	logic rst_n;
	byte_t rx_byte;
	logic rx_valid;
	word_t pc_data;
	logic tx_ready;
	byte_t tx_byte;
	logic tx_valid;
	logic dumping;
	logic clearing;
	// word indexed reference copies of both rams
	word_t iram_model [0:255];
	word_t dram_model [0:255];
	int errors;
	int tests_run;
	int tests_failed;

	mon_top dut (
		.clk(clk), .rst_n(rst_n), .i_rx_byte(rx_byte), .i_rx_valid(rx_valid),
		.i_pc_data(pc_data), .o_tx_byte(tx_byte), .o_tx_valid(tx_valid),
		.i_tx_ready(tx_ready), .o_dumping(dumping), .o_clearing(clearing)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("ERROR: %s at t=%0t", why, $time);
		$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic check_val(input string sig, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAILED t=%0t %s got %h exp %h", $time, sig, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int err0);
		tests_run++;
		if (errors == err0) begin
			$display("PASS: %s", name);
		end else begin
			$display("FAIL: %s, %0d errors", name, errors - err0);
			tests_failed++;
		end
	endtask

	// opcode then four argument bytes msb first
	task automatic send_cmd(input byte_t op, input word_t arg);
		word_t sh;
		sh = arg;
		@(posedge clk);
		rx_byte <= op;
		rx_valid <= 1'b1;
		if (op != `MON_OP_CLEAR && op != `MON_OP_PC && op != `MON_OP_STOP) begin
			for (int k = 0; k < 4; k++) begin
				@(posedge clk);
				rx_byte <= sh[31:24];
				sh = sh << 8;
			end
		end
		@(posedge clk);
		rx_valid <= 1'b0;
	endtask

	// eight accepted bytes lsb first with optional random ready
	task automatic collect_resp(output resp_t r, input logic rnd);
		int n;
		int t;
		n = 0;
		t = 0;
		r = '0;
		while (n < 8) begin
			@(posedge clk);
			if (tx_valid && tx_ready) begin
				r = {tx_byte, r[63:8]};
				n++;
			end
			if (rnd)
				tx_ready <= 1'($urandom_range(1, 0));
			t++;
			if (t > WAIT_LIMIT)
				abort_run("response bytes stopped arriving");
		end
	endtask

	task automatic wait_idle();
		int t;
		t = 0;
		while (dumping) begin
			@(posedge clk);
			t++;
			if (t > WAIT_LIMIT)
				abort_run("o_dumping never fell");
		end
	endtask

	// dump pairs of words from start and compare against the model
	task automatic dump_range(input logic is_iram, input logic [7:0] start, input int pairs,
			input logic rnd);
		logic [7:0] a;
		resp_t got;
		resp_t exp;
		byte_t op_s;
		byte_t op_e;
		op_s = is_iram ? `MON_OP_PSTART : `MON_OP_RSTART;
		op_e = is_iram ? `MON_OP_PEND : `MON_OP_REND;
		send_cmd(op_s, {22'd0, start, 2'b00});
		// exclusive end one past the last word
		send_cmd(op_e, {22'd0, start + 8'(2 * pairs), 2'b00});
		a = start;
		for (int k = 0; k < pairs; k++) begin
			collect_resp(got, rnd);
			if (is_iram)
				exp = {iram_model[a + 8'd1], iram_model[a]};
			else
				exp = {dram_model[a + 8'd1], dram_model[a]};
			check_val($sformatf("o_tx_byte response %0d", k), got, exp);
			a = a + 8'd2;
		end
		wait_idle();
		// nothing extra after the last pair
		check_val("o_tx_valid", 64'(tx_valid), 64'd0);
	endtask

	task automatic test_reset_state();
		int err0;
		err0 = errors;
		check_val("o_tx_valid", 64'(tx_valid), 64'd0);
		check_val("o_dumping", 64'(dumping), 64'd0);
		check_val("o_clearing", 64'(clearing), 64'd0);
		end_test("reset state", err0);
	endtask

	task automatic test_iram_dump();
		int err0;
		word_t w;
		err0 = errors;
		send_cmd(`MON_OP_IADR, 32'h0000_0080);
		for (int k = 0; k < 8; k++) begin
			w = $urandom;
			iram_model[8'h20 + 8'(k)] = w;
			send_cmd(`MON_OP_IDAT, w);
		end
		dump_range(1'b1, 8'h20, 4, 1'b0);
		end_test("iram write and dump", err0);
	endtask

	// start at word 0x12 in the upper half of a line so lanes share lines
	task automatic test_dram_dump();
		int err0;
		word_t w;
		err0 = errors;
		send_cmd(`MON_OP_WADR, 32'h0000_0048);
		for (int k = 0; k < 8; k++) begin
			w = $urandom;
			dram_model[8'h12 + 8'(k)] = w;
			send_cmd(`MON_OP_WDAT, w);
		end
		dump_range(1'b0, 8'h12, 4, 1'b0);
		end_test("dram write and dump", err0);
	endtask

	task automatic test_pc_print();
		int err0;
		word_t pc;
		resp_t got;
		err0 = errors;
		pc = $urandom;
		pc_data <= pc;
		send_cmd(`MON_OP_PC, 32'd0);
		collect_resp(got, 1'b0);
		check_val("o_tx_byte pc response", got, {32'd0, pc});
		wait_idle();
		end_test("pc print", err0);
	endtask

	task automatic test_backpressure();
		int err0;
		err0 = errors;
		dump_range(1'b1, 8'h20, 4, 1'b1);
		tx_ready <= 1'b1;
		end_test("iram dump under back-pressure", err0);
	endtask

	task automatic test_stop();
		int err0;
		int t;
		resp_t got;
		err0 = errors;
		tx_ready <= 1'b0;
		send_cmd(`MON_OP_RSTART, 32'h0000_0048);
		send_cmd(`MON_OP_REND, 32'h0000_0400);
		t = 0;
		while (!tx_valid) begin
			@(posedge clk);
			t++;
			if (t > WAIT_LIMIT)
				abort_run("long dump never offered a byte");
		end
		repeat (4) @(posedge clk);
		check_val("o_dumping", 64'(dumping), 64'd1);
		send_cmd(`MON_OP_STOP, 32'd0);
		wait_idle();
		// first pair still pending in the sender gets drained here
		tx_ready <= 1'b1;
		collect_resp(got, 1'b0);
		check_val("o_tx_byte stalled response", got, {dram_model[8'h13], dram_model[8'h12]});
		@(posedge clk);
		check_val("o_tx_valid", 64'(tx_valid), 64'd0);
		dump_range(1'b0, 8'h12, 4, 1'b0);
		end_test("stop during dram dump", err0);
	endtask

	task automatic test_clear();
		int err0;
		int t;
		int n;
		err0 = errors;
		send_cmd(`MON_OP_CLEAR, 32'd0);
		t = 0;
		while (!clearing) begin
			@(posedge clk);
			t++;
			if (t > WAIT_LIMIT)
				abort_run("o_clearing never rose");
		end
		n = 0;
		while (clearing) begin
			@(posedge clk);
			n++;
			if (n > WAIT_LIMIT)
				abort_run("o_clearing never fell");
		end
		check_val("o_clearing high cycles", 64'(n), 64'd256);
		for (int k = 0; k < 256; k++) begin
			iram_model[k] = '0;
			dram_model[k] = '0;
		end
		dump_range(1'b1, 8'h20, 4, 1'b0);
		dump_range(1'b0, 8'h12, 4, 1'b0);
		end_test("clear both rams", err0);
	endtask

	initial begin
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(7845));
		rst_n <= 1'b0;
		rx_byte <= '0;
		rx_valid <= 1'b0;
		pc_data <= '0;
		tx_ready <= 1'b1;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		test_reset_state();
		test_iram_dump();
		test_dram_dump();
		test_pc_print();
		// back-pressure and stop reuse the data written above and clear goes last
		test_backpressure();
		test_stop();
		test_clear();
		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== verilog/mon_top.sv ====
`timescale 1ns/1ns
`include "mon_consts.svh"

module mon_top (
	input  logic          clk,
	input  logic          rst_n,
	input  mon_pkg::byte_t i_rx_byte,
	input  logic          i_rx_valid,
	input  mon_pkg::word_t i_pc_data,
	output mon_pkg::byte_t o_tx_byte,
	output logic          o_tx_valid,
	input  logic          i_tx_ready,
	output logic          o_dumping,
	output logic          o_clearing
);
	import mon_pkg::*;

	mon_cmd_t cmd;
	word_t arg;
	logic pc_sel;
	logic [`MON_AWIDTH-1:0] iram_radr;
	logic [`MON_AWIDTH-1:0] iram_wadr;
	word_t iram_rdata;
	word_t iram_wdata;
	logic iram_wen;
	wadr_t dram_radr;
	wadr_t dram_wadr;
	logic dram_rd;
	logic dram_valid;
	line_t dram_rdata;
	line_t dram_wdata;
	mask_t dram_mask;
	logic dram_wen;
	logic snd_start;
	logic snd_done;
	resp_t snd_data;

	// host byte stream in
	mon_cmd_decoder u_dec (
		.clk(clk), .rst_n(rst_n), .i_rx_byte(i_rx_byte), .i_rx_valid(i_rx_valid),
		.o_cmd(cmd), .o_arg(arg), .o_pc_sel(pc_sel)
	);

	mon_mem_access u_acc (
		.clk(clk), .rst_n(rst_n), .i_cmd(cmd), .i_arg(arg), .i_pc_sel(pc_sel),
		.i_pc_data(i_pc_data), .o_iram_radr(iram_radr), .i_iram_rdata(iram_rdata),
		.o_iram_wadr(iram_wadr), .o_iram_wdata(iram_wdata), .o_iram_wen(iram_wen),
		.o_dram_radr(dram_radr), .o_dram_rd(dram_rd), .i_dram_rdata(dram_rdata),
		.i_dram_valid(dram_valid), .o_dram_wadr(dram_wadr), .o_dram_wdata(dram_wdata),
		.o_dram_mask(dram_mask), .o_dram_wen(dram_wen), .o_snd_start(snd_start),
		.o_snd_data(snd_data), .i_snd_done(snd_done), .o_dumping(o_dumping),
		.o_clearing(o_clearing)
	);

	// response bytes out
	mon_resp_sender u_snd (
		.clk(clk), .rst_n(rst_n), .i_start(snd_start), .i_data(snd_data),
		.i_tx_ready(i_tx_ready), .o_tx_byte(o_tx_byte), .o_tx_valid(o_tx_valid),
		.o_done(snd_done)
	);

	mon_iram u_iram (
		.clk(clk), .i_radr(iram_radr), .o_rdata(iram_rdata),
		.i_wadr(iram_wadr), .i_wdata(iram_wdata), .i_wen(iram_wen)
	);

	mon_dram u_dram (
		.clk(clk), .rst_n(rst_n), .i_radr(dram_radr), .i_rd(dram_rd),
		.o_rdata(dram_rdata), .o_valid(dram_valid), .i_wadr(dram_wadr),
		.i_wdata(dram_wdata), .i_mask(dram_mask), .i_wen(dram_wen)
	);

endmodule

// ==== verilog/mon_dram.sv ====
`timescale 1ns/1ns
`include "mon_consts.svh"

module mon_dram (
	input  logic          clk,
	input  logic          rst_n,
	input  mon_pkg::wadr_t i_radr,
	input  logic          i_rd,
	output mon_pkg::line_t o_rdata,
	output logic          o_valid,
	input  mon_pkg::wadr_t i_wadr,
	input  mon_pkg::line_t i_wdata,
	input  mon_pkg::mask_t i_mask,
	input  logic          i_wen
);
	import mon_pkg::*;

	// four words per line
	line_t mem [0:(1<<(`MON_AWIDTH-2))-1];
	logic [`MON_DRAM_LAT-1:0] vld_pipe;

	always_ff @(posedge clk) begin
		if (i_wen)
			for (int b = 0; b < 16; b++)
				if (!i_mask[b])
					mem[i_wadr[`MON_AWIDTH-1:2]][8*b +: 8] <= i_wdata[8*b +: 8];
		// line held until the next read
		if (i_rd)
			o_rdata <= mem[i_radr[`MON_AWIDTH-1:2]];
	end

	// valid trails the read strobe by the fixed latency
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			vld_pipe <= '0;
		else
			vld_pipe <= {vld_pipe[`MON_DRAM_LAT-2:0], i_rd};
	end

	assign o_valid = vld_pipe[`MON_DRAM_LAT-1];

endmodule

// ==== verilog/mon_iram.sv ====
`timescale 1ns/1ns
`include "mon_consts.svh"

module mon_iram (
	input  logic                   clk,
	input  logic [`MON_AWIDTH-1:0] i_radr,
	output mon_pkg::word_t          o_rdata,
	input  logic [`MON_AWIDTH-1:0] i_wadr,
	input  mon_pkg::word_t          i_wdata,
	input  logic                   i_wen
);
	import mon_pkg::*;

	word_t mem [0:(1<<`MON_AWIDTH)-1];

	// read returns the old word on a same-address write
	always_ff @(posedge clk) begin
		if (i_wen)
			mem[i_wadr] <= i_wdata;
		o_rdata <= mem[i_radr];
	end

endmodule

// ==== verilog/mon_resp_sender.sv ====
`timescale 1ns/1ns

module mon_resp_sender (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          i_start,
	input  mon_pkg::resp_t i_data,
	input  logic          i_tx_ready,
	output mon_pkg::byte_t o_tx_byte,
	output logic          o_tx_valid,
	output logic          o_done
);
	import mon_pkg::*;

	resp_t shift_q;
	// bytes already accepted
	logic [2:0] byte_cnt;
	logic accept;

	assign accept = o_tx_valid && i_tx_ready;
	// lsb first
	assign o_tx_byte = shift_q[7:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_tx_valid <= 1'b0;
			byte_cnt <= 3'd0;
			o_done <= 1'b0;
		end else begin
			o_done <= accept && (byte_cnt == 3'd7);
			if (i_start) begin
				o_tx_valid <= 1'b1;
				byte_cnt <= 3'd0;
			end else if (accept) begin
				byte_cnt <= byte_cnt + 3'd1;
				if (byte_cnt == 3'd7)
					o_tx_valid <= 1'b0;
			end
		end
	end

	// byte held while ready is low
	always_ff @(posedge clk) begin
		if (i_start)
			shift_q <= i_data;
		else if (accept)
			shift_q <= {8'h00, shift_q[63:8]};
	end

	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n) i_start |-> !o_tx_valid);

endmodule

// ==== verilog/mon_mem_access.sv ====
`timescale 1ns/1ns
`include "mon_consts.svh"

module mon_mem_access (
	input  logic                   clk,
	input  logic                   rst_n,
	input  mon_pkg::mon_cmd_t       i_cmd,
	input  mon_pkg::word_t          i_arg,
	input  logic                   i_pc_sel,
	input  mon_pkg::word_t          i_pc_data,
	output logic [`MON_AWIDTH-1:0] o_iram_radr,
	input  mon_pkg::word_t          i_iram_rdata,
	output logic [`MON_AWIDTH-1:0] o_iram_wadr,
	output mon_pkg::word_t          o_iram_wdata,
	output logic                   o_iram_wen,
	output mon_pkg::wadr_t          o_dram_radr,
	output logic                   o_dram_rd,
	input  mon_pkg::line_t          i_dram_rdata,
	input  logic                   i_dram_valid,
	output mon_pkg::wadr_t          o_dram_wadr,
	output mon_pkg::line_t          o_dram_wdata,
	output mon_pkg::mask_t          o_dram_mask,
	output logic                   o_dram_wen,
	output logic                   o_snd_start,
	output mon_pkg::resp_t          o_snd_data,
	input  logic                   i_snd_done,
	output logic                   o_dumping,
	output logic                   o_clearing
);
	import mon_pkg::*;

	dump_state_t dump_state;
	dump_state_t next_state;
	wadr_t cmd_wadr;
	wadr_t rd_end;
	// extra top bit keeps the end compare safe at wrap
	logic [30:0] rd_adr;
	logic [30:0] iram_radr_w;
	logic dump_end;
	logic iram_step;
	logic line_cap;
	logic snd_wait;
	logic snd_wait_q;
	// top bit is the clear busy flag
	logic [`MON_AWIDTH:0] clr_cnt;
	wadr_t wr_adr;
	word_t wr_word;
	word_t data_0;
	word_t data_1;

	// write address shared by both rams
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cmd_wadr <= '0;
		else if (i_cmd.wadr_set || i_cmd.iadr_set)
			cmd_wadr <= i_arg[31:2];
		else if (i_cmd.wdat_en || i_cmd.idat_en)
			cmd_wadr <= cmd_wadr + 30'd1;
	end

	// clear overrides the command write path
	assign wr_adr = o_clearing ? {{(30-`MON_AWIDTH){1'b0}}, clr_cnt[`MON_AWIDTH-1:0]} : cmd_wadr;
	assign wr_word = o_clearing ? '0 : i_arg;
	assign o_iram_wadr = wr_adr[`MON_AWIDTH-1:0];
	assign o_iram_wdata = wr_word;
	assign o_iram_wen = i_cmd.idat_en | o_clearing;
	// line aligned with only the addressed lane open
	assign o_dram_wadr = {wr_adr[29:2], 2'b00};
	assign o_dram_wdata = {4{wr_word}};
	assign o_dram_mask = ~(mask_t'(16'h000f) << {wr_adr[1:0], 2'b00});
	assign o_dram_wen = i_cmd.wdat_en | o_clearing;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_adr <= '0;
		else if (i_cmd.rstart_set || i_cmd.pstart_set)
			rd_adr <= {1'b0, i_arg[31:2]};
		else if (line_cap)
			rd_adr <= rd_adr + 31'd2;
		else if (iram_step)
			rd_adr <= rd_adr + 31'd1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_end <= '0;
		else if (i_cmd.rend_set || i_cmd.pend_set)
			rd_end <= i_arg[31:2];
	end

	assign dump_end = (rd_adr >= {1'b0, rd_end});
	assign iram_step = (dump_state == IRD1) || (dump_state == IRD2);
	// look one word ahead so the registered read lines up with ird1/ird2
	assign iram_radr_w = iram_step ? rd_adr + 31'd1 : rd_adr;
	assign o_iram_radr = iram_radr_w[`MON_AWIDTH-1:0];
	assign o_dram_radr = {rd_adr[29:2], 2'b00};

	always_comb begin
		next_state = dump_state;
		case (dump_state)
			IDLE: begin
				if (i_cmd.pend_set)
					next_state = IRD1;
				else if (i_cmd.rend_set)
					next_state = DWAIT;
				else if (i_cmd.pc_print)
					next_state = SWAIT;
			end
			IRD1: next_state = i_cmd.stop ? IDLE : IRD2;
			IRD2: next_state = i_cmd.stop ? IDLE : SWAIT;
			DWAIT: begin
				if (i_cmd.stop)
					next_state = IDLE;
				else if (i_dram_valid)
					next_state = DFULL;
			end
			DFULL: begin
				if (i_cmd.stop)
					next_state = IDLE;
				else if (i_snd_done)
					next_state = dump_end ? IDLE : DWAIT;
			end
			SWAIT: begin
				if (i_cmd.stop)
					next_state = IDLE;
				else if (i_snd_done)
					next_state = (i_pc_sel || dump_end) ? IDLE : IRD1;
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dump_state <= IDLE;
		else
			dump_state <= next_state;
	end

	// read strobe on the way into dwait
	assign o_dram_rd = (next_state == DWAIT) && (dump_state != DWAIT);
	assign line_cap = (dump_state == DWAIT) && i_dram_valid;
	assign o_dumping = (dump_state != IDLE);

	// word pair picked by byte address bit 3
	always_ff @(posedge clk) begin
		if (dump_state == IRD1)
			data_0 <= i_iram_rdata;
		else if (line_cap)
			data_0 <= rd_adr[1] ? i_dram_rdata[95:64] : i_dram_rdata[31:0];
		if (dump_state == IRD2)
			data_1 <= i_iram_rdata;
		else if (line_cap)
			data_1 <= rd_adr[1] ? i_dram_rdata[127:96] : i_dram_rdata[63:32];
	end

	assign o_snd_data = i_pc_sel ? {32'd0, i_pc_data} : {data_1, data_0};

	// start pulse on entry to a send wait state
	assign snd_wait = (dump_state == SWAIT) || (dump_state == DFULL);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			snd_wait_q <= 1'b0;
		else
			snd_wait_q <= snd_wait;
	end

	assign o_snd_start = snd_wait && !snd_wait_q;

	// 256 cycles of zero writes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			clr_cnt <= '0;
		else if (i_cmd.clear)
			clr_cnt <= {1'b1, {`MON_AWIDTH{1'b0}}};
		else if (o_clearing)
			clr_cnt <= clr_cnt + (`MON_AWIDTH+1)'(1);
	end

	assign o_clearing = clr_cnt[`MON_AWIDTH];

	// a done in the start cycle would belong to an older response
	a_start_not_done: assert property (@(posedge clk) disable iff (!rst_n)
		o_snd_start |-> !i_snd_done);
	a_no_wr_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		(o_clearing || o_dumping) |-> !(i_cmd.wdat_en || i_cmd.idat_en));

endmodule

// ==== verilog/mon_cmd_decoder.sv ====
`timescale 1ns/1ns
`include "mon_consts.svh"

module mon_cmd_decoder (
	input  logic             clk,
	input  logic             rst_n,
	input  mon_pkg::byte_t    i_rx_byte,
	input  logic             i_rx_valid,
	output mon_pkg::mon_cmd_t o_cmd,
	output mon_pkg::word_t    o_arg,
	output logic             o_pc_sel
);
	import mon_pkg::*;

	byte_t opcode;
	// argument bytes still expected
	logic [2:0] byte_cnt;
	word_t arg_shift;
	byte_t done_op;
	mon_cmd_t cmd_dec;
	logic op_phase;
	logic arg_phase;
	logic single_op;
	logic arg_start;
	logic cmd_done;

	assign op_phase = i_rx_valid && (byte_cnt == 3'd0);
	assign arg_phase = i_rx_valid && (byte_cnt != 3'd0);
	// opcode of the command that may finish this cycle
	assign done_op = op_phase ? i_rx_byte : opcode;

	always_comb begin
		cmd_dec = '0;
		case (done_op)
			`MON_OP_WADR:   cmd_dec.wadr_set = 1'b1;
			`MON_OP_WDAT:   cmd_dec.wdat_en = 1'b1;
			`MON_OP_IADR:   cmd_dec.iadr_set = 1'b1;
			`MON_OP_IDAT:   cmd_dec.idat_en = 1'b1;
			`MON_OP_RSTART: cmd_dec.rstart_set = 1'b1;
			`MON_OP_REND:   cmd_dec.rend_set = 1'b1;
			`MON_OP_PSTART: cmd_dec.pstart_set = 1'b1;
			`MON_OP_PEND:   cmd_dec.pend_set = 1'b1;
			`MON_OP_STOP:   cmd_dec.stop = 1'b1;
			`MON_OP_CLEAR:  cmd_dec.clear = 1'b1;
			`MON_OP_PC:     cmd_dec.pc_print = 1'b1;
			default:        cmd_dec = '0;
		endcase
	end

	// c g x carry no argument
	assign single_op = cmd_dec.stop | cmd_dec.clear | cmd_dec.pc_print;
	// unknown bytes fall through and are dropped
	assign arg_start = op_phase && (|cmd_dec) && !single_op;
	assign cmd_done = (op_phase && single_op) || (arg_phase && (byte_cnt == 3'd1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			opcode <= '0;
			byte_cnt <= 3'd0;
			o_cmd <= '0;
			o_pc_sel <= 1'b0;
		end else begin
			o_cmd <= cmd_done ? cmd_dec : '0;
			if (arg_start) begin
				opcode <= i_rx_byte;
				byte_cnt <= 3'd4;
			end else if (arg_phase) begin
				byte_cnt <= byte_cnt - 3'd1;
			end
			// pc print select, dropped again by any dump range command
			if (cmd_done && cmd_dec.pc_print)
				o_pc_sel <= 1'b1;
			else if (cmd_done && (cmd_dec.pstart_set || cmd_dec.pend_set ||
					cmd_dec.rstart_set || cmd_dec.rend_set))
				o_pc_sel <= 1'b0;
		end
	end

	// msb first, argument word held until the next command completes
	always_ff @(posedge clk) begin
		if (arg_phase)
			arg_shift <= {arg_shift[23:0], i_rx_byte};
		if (arg_phase && (byte_cnt == 3'd1))
			o_arg <= {arg_shift[23:0], i_rx_byte};
	end

	a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(o_cmd));

endmodule

// ==== verilog/mon_pkg.sv ====
package mon_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [31:0] word_t;
	// word address, byte address bits 31..2
	typedef logic [29:0] wadr_t;
	typedef logic [63:0] resp_t;
	typedef logic [127:0] line_t;
	// set bit keeps its byte unchanged
	typedef logic [15:0] mask_t;

	// one strobe per host command
	typedef struct packed {
		logic wadr_set;
		logic wdat_en;
		logic iadr_set;
		logic idat_en;
		logic rstart_set;
		logic rend_set;
		logic pstart_set;
		logic pend_set;
		logic stop;
		logic clear;
		logic pc_print;
	} mon_cmd_t;

	typedef enum logic [2:0] {IDLE, IRD1, IRD2, DWAIT, DFULL, SWAIT} dump_state_t;

endpackage

// ==== include/mon_consts.svh ====
`ifndef MON_CONSTS_SVH
`define MON_CONSTS_SVH

// word address bits per ram, 256 words each
`define MON_AWIDTH 8

// host opcode bytes, ascii letters
`define MON_OP_WADR   8'h61
`define MON_OP_WDAT   8'h77
`define MON_OP_IADR   8'h69
`define MON_OP_IDAT   8'h6a
`define MON_OP_RSTART 8'h73
`define MON_OP_REND   8'h65
`define MON_OP_PSTART 8'h70
`define MON_OP_PEND   8'h71
`define MON_OP_STOP   8'h78
`define MON_OP_CLEAR  8'h63
`define MON_OP_PC     8'h67

// cycles from data ram read strobe to read valid
`define MON_DRAM_LAT 2

`endif
